// File: common/dma_pkg.sv
// DMA package with bus, network flit, request and register field definitions
package dma_pkg;

  //////////////////////////////////////////////////
  // Basic words
  //////////////////////////////////////////////////

  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] data_t;  // Bus and payload word
  typedef logic [7:0]  len_t;   // Words per transfer, zero counts as one

  //////////////////////////////////////////////////
  // Network link
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FLIT_HEAD = 2'd0,  // Payload is the destination address
    FLIT_BODY = 2'd1,
    FLIT_TAIL = 2'd2   // Last data word of a packet
  } flit_kind_e;

  typedef struct packed {
    flit_kind_e kind;
    data_t      payload;
  } flit_t;  // 34 bits

  //////////////////////////////////////////////////
  // Request table entry
  //////////////////////////////////////////////////

  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } dma_req_t;  // 72 bits

  // Register offsets inside one 16-byte entry, from addr[3:2]
  typedef enum logic [1:0] {
    REG_SRC  = 2'd0,
    REG_DST  = 2'd1,
    REG_LEN  = 2'd2,
    REG_CTRL = 2'd3   // Bit 0 valid/start, bit 1 done
  } reg_field_e;

  //////////////////////////////////////////////////
  // Memory bus and configuration bus
  //////////////////////////////////////////////////

  typedef struct packed {
    logic  sel;
    logic  write;
    logic  lock;   // Raised with sel, holds the arbiter grant
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  ready;  // Access complete, rdata valid
  } bus_rsp_t;

  typedef struct packed {
    logic  sel;    // One cycle per access
    logic  write;
    addr_t addr;
    data_t wdata;
  } cfg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  ready;  // Exactly one cycle after sel
  } cfg_rsp_t;

endpackage

// File: hdl/dma_reg_decode.sv
// Configuration slave turning register accesses into table strobes and status reads
`timescale 1ns/1ps

module dma_reg_decode import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4,
  localparam int PTR_WIDTH    = $clog2(TABLE_ENTRIES)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  cfg_req_t                 cfg_req,
  output cfg_rsp_t                 cfg_rsp,
  output logic                     write_en,     // Field write strobe
  output logic [PTR_WIDTH-1:0]     write_pos,
  output reg_field_e               write_field,
  output data_t                    write_data,
  output logic                     ctrl_en,      // Control write strobe
  output logic                     ctrl_start,
  output logic [PTR_WIDTH-1:0]     read_pos,
  input  dma_req_t                 read_req,     // Entry at read_pos
  input  logic [TABLE_ENTRIES-1:0] valid,
  input  logic [TABLE_ENTRIES-1:0] done
);

  reg_field_e           field;
  logic [PTR_WIDTH-1:0] pos;
  logic                 wr;
  data_t                rdata_next;
  data_t                rsp_rdata;
  logic                 rsp_ready;

  //////////////////////////////////////////////////
  // Address split and write strobes
  //////////////////////////////////////////////////

  assign field = reg_field_e'(cfg_req.addr[3:2]);
  assign pos   = cfg_req.addr[4 +: PTR_WIDTH];  // 16 bytes per entry
  assign wr    = cfg_req.sel & cfg_req.write;

  assign write_en    = wr & (field != REG_CTRL);
  assign ctrl_en     = wr & (field == REG_CTRL);
  assign ctrl_start  = cfg_req.wdata[0];          // Clear means done clear only
  assign write_pos   = pos;
  assign write_field = field;
  assign write_data  = cfg_req.wdata;
  assign read_pos    = pos;

  //////////////////////////////////////////////////
  // Read data and response
  //////////////////////////////////////////////////

  always_comb begin
    case (field)
      REG_SRC: rdata_next = read_req.src;
      REG_DST: rdata_next = read_req.dst;
      REG_LEN: rdata_next = data_t'(read_req.len);  // Zero extended
      default: rdata_next = {30'd0, done[pos], valid[pos]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_ready <= 1'b0;
    end else begin
      rsp_ready <= cfg_req.sel;  // Fixed one-cycle latency
    end
  end

  // Sampled with the access, shown with ready
  always_ff @(posedge clk) begin
    if (cfg_req.sel) begin
      rsp_rdata <= rdata_next;
    end
  end

  assign cfg_rsp.rdata = rsp_rdata;
  assign cfg_rsp.ready = rsp_ready;

endmodule

// File: dma_table/dma_request_table.sv
// Request table storing copy requests with valid and done bits and level interrupts
`timescale 1ns/1ps

module dma_request_table import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4,
  localparam int PTR_WIDTH    = $clog2(TABLE_ENTRIES)
) (
  input  logic                     clk,
  input  logic                     rst,
  // Configuration side
  input  logic                     write_en,
  input  logic [PTR_WIDTH-1:0]     write_pos,
  input  reg_field_e               write_field,
  input  data_t                    write_data,
  input  logic                     ctrl_en,
  input  logic                     ctrl_start,
  input  logic [PTR_WIDTH-1:0]     cfg_pos,
  output dma_req_t                 cfg_req_out,
  // Engine side
  input  logic [PTR_WIDTH-1:0]     exec_pos,
  output dma_req_t                 exec_req,
  input  logic                     done_en,      // One-cycle completion pulse
  input  logic [PTR_WIDTH-1:0]     done_pos,
  // Status
  output logic [TABLE_ENTRIES-1:0] valid,
  output logic [TABLE_ENTRIES-1:0] done,
  output logic [TABLE_ENTRIES-1:0] irq
);

  dma_req_t reqs [TABLE_ENTRIES];  // Request storage

  //////////////////////////////////////////////////
  // Field storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (write_en) begin
      case (write_field)
        REG_SRC: reqs[write_pos].src <= write_data;
        REG_DST: reqs[write_pos].dst <= write_data;
        REG_LEN: reqs[write_pos].len <= write_data[$bits(len_t)-1:0];
        default: ;  // Control goes through ctrl_en
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Valid and done bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      done  <= '0;
    end else begin
      if (ctrl_en) begin
        done[write_pos] <= 1'b0;  // Any control write acknowledges
        if (ctrl_start) begin
          valid[write_pos] <= 1'b1;
        end
      end
      // Placed last so completion wins over a start on the same entry
      if (done_en) begin
        valid[done_pos] <= 1'b0;
        done[done_pos]  <= 1'b1;
      end
    end
  end

  // Read ports, both asynchronous
  assign cfg_req_out = reqs[cfg_pos];
  assign exec_req    = reqs[exec_pos];

  assign irq = done;  // Level interrupt per entry

endmodule

// File: dma_engine/dma_initiator.sv
// Transfer engine reading source words and sending them as packets under credit control
`timescale 1ns/1ps

module dma_initiator import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4,
  parameter int NOC_CREDITS   = 4,
  localparam int PTR_WIDTH    = $clog2(TABLE_ENTRIES),
  localparam int CW           = $clog2(NOC_CREDITS + 1)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [TABLE_ENTRIES-1:0] valid,
  output logic [PTR_WIDTH-1:0]     exec_pos,
  input  dma_req_t                 exec_req,
  output logic                     done_en,
  output logic [PTR_WIDTH-1:0]     done_pos,
  output flit_t                    noc_out_flit,
  output logic                     noc_out_valid,
  input  logic                     noc_out_credit,  // One pulse per freed slot
  output bus_req_t                 bus_req,
  input  bus_rsp_t                 bus_rsp
);

  typedef enum logic [1:0] {
    IDLE,  // Wait for a valid entry
    HEAD,  // Send destination address
    READ,  // Fetch one source word
    SEND   // Send it as body or tail
  } state_e;

  state_e               state;
  logic [CW-1:0]        credits;
  len_t                 idx;       // Current word
  data_t                word;      // Fetched source word
  logic                 has_credit;
  logic                 sent;
  logic                 last;
  logic [PTR_WIDTH-1:0] low_pos;

  //////////////////////////////////////////////////
  // Entry pick and word tracking
  //////////////////////////////////////////////////

  // Lowest valid entry wins
  always_comb begin
    low_pos = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid[i]) low_pos = PTR_WIDTH'(i);
    end
  end

  assign has_credit = (credits != '0);
  assign sent       = noc_out_valid;  // No ready, credits guarantee room
  assign last       = ({1'b0, idx} + 9'd1) >= {1'b0, exec_req.len};  // Len 0 acts as 1

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign noc_out_valid = has_credit & ((state == HEAD) | (state == SEND));
  assign noc_out_flit.kind    = (state == HEAD) ? FLIT_HEAD :
                                last            ? FLIT_TAIL : FLIT_BODY;
  assign noc_out_flit.payload = (state == HEAD) ? exec_req.dst : word;

  assign done_en  = (state == SEND) & sent & last;  // Tail leaves this cycle
  assign done_pos = exec_pos;

  assign bus_req.sel   = (state == READ);
  assign bus_req.write = 1'b0;
  assign bus_req.lock  = (state == READ);  // Lock with every access
  assign bus_req.addr  = exec_req.src + {22'd0, idx, 2'b00};
  assign bus_req.wdata = '0;

  //////////////////////////////////////////////////
  // FSM and credit counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      credits  <= CW'(NOC_CREDITS);  // Receiver starts empty
      idx      <= '0;
      exec_pos <= '0;
    end else begin
      case ({noc_out_credit, sent})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;  // Both or neither
      endcase
      case (state)
        IDLE: if (|valid) begin
          exec_pos <= low_pos;
          state    <= HEAD;
        end
        HEAD: if (sent) begin
          idx   <= '0;
          state <= READ;
        end
        READ: if (bus_rsp.ready) state <= SEND;
        SEND: if (sent) begin
          if (last) begin
            state <= IDLE;  // Table clears valid at this edge
          end else begin
            idx   <= idx + 1'b1;
            state <= READ;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == READ) && bus_rsp.ready) begin
      word <= bus_rsp.rdata;
    end
  end

endmodule

// File: dma_engine/dma_target.sv
// Packet receiver with a credit-returning FIFO that writes payload words to memory
`timescale 1ns/1ps

module dma_target import dma_pkg::*; #(
  parameter int NOC_CREDITS = 4,
  localparam int PW         = (NOC_CREDITS > 1) ? $clog2(NOC_CREDITS) : 1,
  localparam int CW         = $clog2(NOC_CREDITS + 1)
) (
  input  logic     clk,
  input  logic     rst,
  input  flit_t    noc_in_flit,
  input  logic     noc_in_valid,
  output logic     noc_in_credit,  // One cycle after each dequeue
  output bus_req_t bus_req,
  input  bus_rsp_t bus_rsp
);

  flit_t         fifo [NOC_CREDITS];  // Sized to the sender credits
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  flit_t         head;
  logic          empty;
  logic          deq;
  addr_t         wr_addr;  // Next destination address

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    return (p == PW'(NOC_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign head  = fifo[rd_ptr];

  // Head flits just load the address, data flits wait for the write
  assign deq = ~empty & ((head.kind == FLIT_HEAD) | (bus_req.sel & bus_rsp.ready));

  //////////////////////////////////////////////////
  // Memory write side
  //////////////////////////////////////////////////

  assign bus_req.sel   = ~empty & (head.kind != FLIT_HEAD);
  assign bus_req.write = 1'b1;
  assign bus_req.lock  = bus_req.sel;
  assign bus_req.addr  = wr_addr;
  assign bus_req.wdata = head.payload;  // Held until ready

  always_ff @(posedge clk) begin
    if (noc_in_valid) begin
      fifo[wr_ptr] <= noc_in_flit;
    end
    if (deq) begin
      wr_addr <= (head.kind == FLIT_HEAD) ? head.payload : wr_addr + 32'd4;
    end
  end

  //////////////////////////////////////////////////
  // FIFO control and credit return
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      noc_in_credit <= 1'b0;
    end else begin
      if (noc_in_valid) wr_ptr <= ptr_next(wr_ptr);  // Never full, sender counts
      if (deq) rd_ptr <= ptr_next(rd_ptr);
      count         <= count + CW'(noc_in_valid) - CW'(deq);
      noc_in_credit <= deq;
    end
  end

endmodule

// File: hdl/dma_bus_arbiter.sv
// Two-master memory bus arbiter whose grant is held while the owner keeps lock high
`timescale 1ns/1ps

module dma_bus_arbiter import dma_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t init_req,
  output bus_rsp_t init_rsp,
  input  bus_req_t targ_req,
  output bus_rsp_t targ_rsp,
  output bus_req_t mem_req,
  input  bus_rsp_t mem_rsp
);

  logic grant_targ;  // 1 target owns the bus, 0 initiator
  logic owner_lock;
  logic grant_next;

  //////////////////////////////////////////////////
  // Grant selection
  //////////////////////////////////////////////////

  assign owner_lock = grant_targ ? targ_req.lock : init_req.lock;

  always_comb begin
    if (owner_lock) begin
      grant_next = grant_targ;  // Hold during a locked access
    end else if (targ_req.lock) begin
      grant_next = 1'b1;        // Target first
    end else if (init_req.lock) begin
      grant_next = 1'b0;
    end else begin
      grant_next = 1'b1;        // Park on target
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_targ <= 1'b1;
    end else begin
      grant_targ <= grant_next;
    end
  end

  //////////////////////////////////////////////////
  // Request and response routing
  //////////////////////////////////////////////////

  assign mem_req = grant_targ ? targ_req : init_req;

  assign init_rsp.rdata = mem_rsp.rdata;
  assign init_rsp.ready = mem_rsp.ready & ~grant_targ;  // Loser sees no ready
  assign targ_rsp.rdata = mem_rsp.rdata;
  assign targ_rsp.ready = mem_rsp.ready & grant_targ;

endmodule

// File: hdl/dma_top.sv
// DMA subsystem top connecting configuration slave, request table, engines and arbiter
`timescale 1ns/1ps

module dma_top import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4,
  parameter int NOC_CREDITS   = 4,
  localparam int PTR_WIDTH    = $clog2(TABLE_ENTRIES)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  cfg_req_t                 cfg_req,
  output cfg_rsp_t                 cfg_rsp,
  output flit_t                    noc_out_flit,
  output logic                     noc_out_valid,
  input  logic                     noc_out_credit,
  input  flit_t                    noc_in_flit,
  input  logic                     noc_in_valid,
  output logic                     noc_in_credit,
  output bus_req_t                 mem_req,
  input  bus_rsp_t                 mem_rsp,
  output logic [TABLE_ENTRIES-1:0] irq
);

  // Configuration to table
  logic                     write_en;
  logic [PTR_WIDTH-1:0]     write_pos;
  reg_field_e               write_field;
  data_t                    write_data;
  logic                     ctrl_en;
  logic                     ctrl_start;
  logic [PTR_WIDTH-1:0]     read_pos;
  dma_req_t                 read_req;
  logic [TABLE_ENTRIES-1:0] valid;
  logic [TABLE_ENTRIES-1:0] done;
  // Table to engine
  logic [PTR_WIDTH-1:0]     exec_pos;
  dma_req_t                 exec_req;
  logic                     done_en;
  logic [PTR_WIDTH-1:0]     done_pos;
  // Bus masters
  bus_req_t                 init_req;
  bus_rsp_t                 init_rsp;
  bus_req_t                 targ_req;
  bus_rsp_t                 targ_rsp;

  dma_reg_decode #(.TABLE_ENTRIES(TABLE_ENTRIES)) u_reg_decode (
    .clk, .rst, .cfg_req, .cfg_rsp,
    .write_en, .write_pos, .write_field, .write_data,
    .ctrl_en, .ctrl_start, .read_pos, .read_req, .valid, .done
  );

  dma_request_table #(.TABLE_ENTRIES(TABLE_ENTRIES)) u_request_table (
    .clk, .rst, .write_en, .write_pos, .write_field, .write_data,
    .ctrl_en, .ctrl_start, .cfg_pos(read_pos), .cfg_req_out(read_req),
    .exec_pos, .exec_req, .done_en, .done_pos, .valid, .done, .irq
  );

  dma_initiator #(.TABLE_ENTRIES(TABLE_ENTRIES), .NOC_CREDITS(NOC_CREDITS)) u_initiator (
    .clk, .rst, .valid, .exec_pos, .exec_req, .done_en, .done_pos,
    .noc_out_flit, .noc_out_valid, .noc_out_credit,
    .bus_req(init_req), .bus_rsp(init_rsp)
  );

  dma_target #(.NOC_CREDITS(NOC_CREDITS)) u_target (
    .clk, .rst, .noc_in_flit, .noc_in_valid, .noc_in_credit,
    .bus_req(targ_req), .bus_rsp(targ_rsp)
  );

  dma_bus_arbiter u_bus_arbiter (
    .clk, .rst, .init_req, .init_rsp, .targ_req, .targ_rsp, .mem_req, .mem_rsp
  );

endmodule

// File: bench/dma_tb_models.sv
// Testbench models for the DMA subsystem: a clock source and a memory with random wait states
`timescale 1ns/1ps

//////////////////////////////////////////////////
// Clock source
//////////////////////////////////////////////////

module dma_tb_clock #(
  parameter int HALF_PERIOD = 2  // ns, so a 4 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule

//////////////////////////////////////////////////
// Word memory behind the shared bus
//////////////////////////////////////////////////

module dma_tb_memory import dma_pkg::*; #(
  parameter int WORDS = 1024,
  localparam int AW   = $clog2(WORDS)
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] wait_cycles,  // New random value each cycle
  input  bus_req_t   mem_req,
  output bus_rsp_t   mem_rsp
);

  data_t         mem [WORDS];
  logic          busy;      // Access accepted, counting waits
  logic          [1:0] left;
  logic [AW-1:0] idx;

  assign idx = mem_req.addr[AW+1:2];  // Word index

  // Fill pattern uses every address bit
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = data_t'(i) * 32'h9e3779b9 ^ 32'h0f1e2d3c;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      busy          <= 1'b0;
      left          <= '0;
      mem_rsp.ready <= 1'b0;
    end else begin
      mem_rsp.ready <= 1'b0;  // Single-cycle ready
      if (busy) begin
        if (left == '0) begin
          busy          <= 1'b0;
          mem_rsp.ready <= 1'b1;
          mem_rsp.rdata <= mem[idx];
          if (mem_req.write) mem[idx] <= mem_req.wdata;  // Master holds the request
        end else begin
          left <= left - 1'b1;
        end
      end else if (mem_req.sel && !mem_rsp.ready) begin
        busy <= 1'b1;  // Skip the cycle the last access ends
        left <= wait_cycles;
      end
    end
  end

endmodule

// File: bench/dma_tb.sv
// Testbench for the DMA subsystem with network loopback, memory model and reference copy
`timescale 1ns/1ps

module dma_tb import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4,
  parameter int NOC_CREDITS   = 4
);

  localparam logic [31:0] SEED         = 32'hb55c628e;
  localparam int          MEM_WORDS    = 1024;  // 4 KB with word index from addr[11:2]
  localparam int          REGION_BYTES = 256;   // 64 words per entry
  localparam int          DST_BASE     = 2048;  // Destinations in the upper half
  localparam int          BASE_LIMIT   = 2000;

  logic                     clk;
  logic                     rst;
  cfg_req_t                 cfg_req;
  cfg_rsp_t                 cfg_rsp;
  flit_t                    noc_flit;    // Out link looped to in link
  logic                     noc_valid;
  logic                     noc_credit;  // Credits looped back too
  bus_req_t                 mem_req;
  bus_rsp_t                 mem_rsp;
  logic [TABLE_ENTRIES-1:0] irq;
  logic [1:0]               wait_cycles = '0;
  logic [31:0]              stim_state  = SEED;
  logic [31:0]              wait_state  = SEED;
  data_t                    init_mem [MEM_WORDS];  // Memory before any copy
  dma_req_t                 started [$];           // Requests in start order
  int unsigned              cycles      = 0;
  int unsigned              cycle_limit = BASE_LIMIT;
  int unsigned              writes_seen = 0;
  int unsigned              writes_exp  = 0;
  // Link tracking
  dma_req_t                 active [TABLE_ENTRIES];                    // Last start per entry
  int unsigned              starts [TABLE_ENTRIES] = '{default: 0};
  int unsigned              tails  [TABLE_ENTRIES] = '{default: 0};   // Packets finished
  int                       pkt_pos   = -1;  // Entry whose packet is on the link
  int                       pkt_index = 0;   // Data words seen in that packet
  int                       in_flight = 0;   // Flits sent, credits not yet back

  dma_tb_clock u_clock (.clk);

  dma_top #(.TABLE_ENTRIES(TABLE_ENTRIES), .NOC_CREDITS(NOC_CREDITS)) DUT (
    .clk, .rst, .cfg_req, .cfg_rsp,
    .noc_out_flit(noc_flit), .noc_out_valid(noc_valid), .noc_out_credit(noc_credit),
    .noc_in_flit(noc_flit), .noc_in_valid(noc_valid), .noc_in_credit(noc_credit),
    .mem_req, .mem_rsp, .irq
  );

  dma_tb_memory #(.WORDS(MEM_WORDS)) u_memory (.clk, .rst, .wait_cycles, .mem_req, .mem_rsp);

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] draw(inout logic [31:0] state, input int bits);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < bits; b++) begin
      value = {value[30:0], state[31]};  // One step per bit
      state = lfsr_step(state);
    end
    return value;
  endfunction

  function automatic int req_words(input dma_req_t r);
    return (r.len == '0) ? 1 : int'(r.len);  // Zero length moves one word
  endfunction

  function automatic dma_req_t entry_req(input int pos);
    dma_req_t r;
    r.src = addr_t'(pos * REGION_BYTES);
    r.dst = addr_t'(DST_BASE + pos * REGION_BYTES);
    r.len = len_t'(draw(stim_state, 5));  // 0 to 31
    return r;
  endfunction

  // Expected word after every started copy where later requests win
  function automatic data_t copy_ref(input int w);
    data_t value;
    int    s;
    int    d;
    value = init_mem[w];
    foreach (started[k]) begin
      s = int'(started[k].src >> 2);
      d = int'(started[k].dst >> 2);
      if (w >= d && w < d + req_words(started[k])) value = init_mem[s + w - d];
    end
    return value;
  endfunction

  // Engine serves the lowest started entry whose packet has not ended
  function automatic int lowest_pending();
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      if (starts[i] != tails[i]) return i;
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_req(input string name, input dma_req_t got, input dma_req_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_irq(input string name, input logic [TABLE_ENTRIES-1:0] got,
                           input logic [TABLE_ENTRIES-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_memory();
    for (int w = 0; w < MEM_WORDS; w++) begin
      check_data($sformatf("mem[%0d]", w), u_memory.mem[w], copy_ref(w));
    end
    check_data("memory write count", data_t'(writes_seen), data_t'(writes_exp));
  endtask

  //////////////////////////////////////////////////
  // Configuration accesses
  //////////////////////////////////////////////////

  task automatic cfg_access(input logic wr, input addr_t a, input data_t d, output data_t rdata);
    @(posedge clk);
    cfg_req <= '{sel: 1'b1, write: wr, addr: a, wdata: d};
    @(posedge clk);
    cfg_req.sel <= 1'b0;  // One cycle per access
    @(negedge clk);
    if (cfg_rsp.ready !== 1'b1) begin
      abort_run("Configuration slave gave no ready one cycle after access");
    end
    rdata = cfg_rsp.rdata;
  endtask

  function automatic addr_t reg_addr(input int pos, input reg_field_e field);
    return (addr_t'(pos) << 4) | (addr_t'(field) << 2);
  endfunction

  task automatic cfg_write(input int pos, input reg_field_e field, input data_t d);
    data_t unused;
    cfg_access(1'b1, reg_addr(pos, field), d, unused);
  endtask

  task automatic cfg_read(input int pos, input reg_field_e field, output data_t d);
    cfg_access(1'b0, reg_addr(pos, field), '0, d);
  endtask

  task automatic program_entry(input int pos, input dma_req_t r);
    cfg_write(pos, REG_SRC, r.src);
    cfg_write(pos, REG_DST, r.dst);
    cfg_write(pos, REG_LEN, data_t'(r.len));
  endtask

  task automatic read_entry(input int pos, output dma_req_t r);
    data_t rd;
    cfg_read(pos, REG_SRC, rd);
    r.src = rd;
    cfg_read(pos, REG_DST, rd);
    r.dst = rd;
    cfg_read(pos, REG_LEN, rd);
    check_data("len register upper bits", rd & 32'hffffff00, '0);
    r.len = len_t'(rd);
  endtask

  task automatic start_entry(input int pos, input dma_req_t r);
    started.push_back(r);  // Reference knows the copy before it runs
    active[pos] = r;
    starts[pos]++;
    writes_exp  += req_words(r);
    cycle_limit += 20 * req_words(r);
    cfg_write(pos, REG_CTRL, 32'h1);
  endtask

  task automatic wait_copy(input logic [TABLE_ENTRIES-1:0] mask);
    while ((irq & mask) != mask) @(negedge clk);
    // Target may still be writing the tail and returning credits after done
    while (writes_seen < writes_exp || mem_req.sel || in_flight != 0) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////

  always @(posedge clk) wait_cycles <= 2'(draw(wait_state, 2));

  // Every completed memory write against the reference
  always @(negedge clk) begin
    if (!rst && mem_req.sel && mem_req.write && mem_rsp.ready) begin
      check_data($sformatf("write data at %h", mem_req.addr), mem_req.wdata,
                 copy_ref(int'(mem_req.addr[11:2])));
      writes_seen <= writes_seen + 1;
    end
  end

  // Credit rule and packet framing on the looped network link
  always @(negedge clk) begin
    flit_t    exp_flit;
    dma_req_t r;
    if (!rst) begin
      if (noc_valid && in_flight >= NOC_CREDITS) begin
        abort_run("Initiator sent a flit with no credit left");
      end
      if (noc_credit && in_flight == 0) begin
        abort_run("Target returned a credit with no flit outstanding");
      end
      if (noc_valid) begin
        if (pkt_pos < 0) begin
          pkt_pos = lowest_pending();
          if (pkt_pos < 0) begin
            abort_run("Flit on the network link with no transfer started");
          end else begin
            pkt_index = 0;
            exp_flit  = '{kind: FLIT_HEAD, payload: active[pkt_pos].dst};
            check_flit($sformatf("head flit of entry %0d", pkt_pos), noc_flit, exp_flit);
          end
        end else begin
          r                = active[pkt_pos];
          exp_flit.kind    = (pkt_index + 1 == req_words(r)) ? FLIT_TAIL : FLIT_BODY;
          exp_flit.payload = init_mem[int'(r.src >> 2) + pkt_index];
          check_flit($sformatf("flit %0d of entry %0d", pkt_index, pkt_pos),
                     noc_flit, exp_flit);
          pkt_index++;
          if (exp_flit.kind == FLIT_TAIL) begin
            tails[pkt_pos]++;
            pkt_pos = -1;
          end
        end
      end
      in_flight <= in_flight + int'(noc_valid) - int'(noc_credit);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles waiting for the DMA", cycles));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    dma_req_t                 req;
    dma_req_t                 got;
    dma_req_t                 reqs [TABLE_ENTRIES];
    data_t                    rd;
    logic [TABLE_ENTRIES-1:0] mask;
    int                       pos;

    cfg_req = '0;
    rst     = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_irq("irq after reset", irq, '0);

    // Random source words and a snapshot of the whole memory
    for (int w = 0; w < TABLE_ENTRIES * REGION_BYTES / 4; w++) begin
      u_memory.mem[w] = draw(stim_state, 32);
    end
    for (int w = 0; w < MEM_WORDS; w++) init_mem[w] = u_memory.mem[w];

    // Register write and readback of every entry
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      req.src = draw(stim_state, 32);
      req.dst = draw(stim_state, 32);
      req.len = len_t'(draw(stim_state, 8));
      program_entry(i, req);
      read_entry(i, got);
      check_req($sformatf("entry %0d readback", i), got, req);
    end

    // Single transfer
    pos       = TABLE_ENTRIES / 2;
    req       = entry_req(pos);
    mask      = '0;
    mask[pos] = 1'b1;
    program_entry(pos, req);
    start_entry(pos, req);
    wait_copy(mask);
    check_memory();
    check_irq("irq", irq, mask);
    cfg_read(pos, REG_CTRL, rd);
    check_data($sformatf("ctrl of entry %0d", pos), rd, 32'h2);  // Valid 0 and done 1

    // All entries at once
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      reqs[i] = entry_req(i);
      program_entry(i, reqs[i]);
    end
    for (int i = 0; i < TABLE_ENTRIES; i++) start_entry(i, reqs[i]);
    wait_copy('1);
    check_memory();
    check_irq("irq", irq, '1);

    // Done clear on one entry only
    pos = 1;
    cfg_write(pos, REG_CTRL, '0);
    mask      = '1;
    mask[pos] = 1'b0;
    check_irq("irq after done clear", irq, mask);
    cfg_read(pos, REG_CTRL, rd);
    check_data($sformatf("ctrl of entry %0d", pos), rd, '0);
    cfg_read(0, REG_CTRL, rd);
    check_data("ctrl of entry 0", rd, 32'h2);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: list.f
common/dma_pkg.sv
hdl/dma_reg_decode.sv
dma_table/dma_request_table.sv
dma_engine/dma_initiator.sv
dma_engine/dma_target.sv
hdl/dma_bus_arbiter.sv
hdl/dma_top.sv
bench/dma_tb_models.sv
bench/dma_tb.sv

// File: Makefile
# Verilator build of the DMA testbench, one binary per NOC_CREDITS setting
VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
CREDITS   ?= 4 1
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	@set -e; for c in $(CREDITS); do \
	  $(VERILATOR) $(VFLAGS) --top-module $(TOP) -GNOC_CREDITS=$$c \
	    -f $(FILELIST) --Mdir $(BUILD_DIR)/credits_$$c; \
	done

run: compile
	@set -e; for c in $(CREDITS); do \
	  echo "Simulating with NOC_CREDITS=$$c"; \
	  $(BUILD_DIR)/credits_$$c/V$(TOP); \
	done

clean:
	rm -rf $(BUILD_DIR)
